// ==== src/search_settings.svh ====
`ifndef SEARCH_SETTINGS_SVH
`define SEARCH_SETTINGS_SVH

// move encoding width, from/to squares plus promotion piece
`define SEARCH_MOVE_BITS 16

// signed score width
`define SEARCH_EVAL_BITS 16

// children kept per node
`define SEARCH_MAX_MOVES 16

// full alpha/beta window is -INF..+INF
`define SEARCH_SCORE_INF 32700

// node with no children reports this
`define SEARCH_SCORE_NONE (-32760)

// child scores at or below -MATE_BAND are mate scores
`define SEARCH_MATE_BAND 32700

`endif

// ==== src/search_pkg.sv ====
`include "search_settings.svh"

package search_pkg;

    // promotion takes what is left after the two squares
    typedef struct packed {
        logic [5:0] from_sq;
        logic [5:0] to_sq;
        logic [`SEARCH_MOVE_BITS-13:0] promo;
    } move_t;

    typedef logic signed [`SEARCH_EVAL_BITS-1:0] eval_t;

    // parent-side score with the sign bit flipped, compares unsigned
    typedef logic [`SEARCH_EVAL_BITS-1:0] sort_key_t;

    // score is from the child's point of view
    typedef struct packed {
        move_t move;
        eval_t score;
    } scored_move_t;

    typedef struct packed {
        eval_t alpha;
        eval_t beta;
    } window_t;

    typedef logic [$clog2(`SEARCH_MAX_MOVES + 1)-1:0] count_t;

    typedef struct packed {
        move_t  best_move;
        eval_t  best_score;
        eval_t  new_alpha;
        logic   cutoff;
        count_t examined;
    } fold_result_t;

endpackage

// ==== src/stream_sorter.sv ====
`timescale 1ns/1ps
`include "search_settings.svh"

module stream_sorter #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = `SEARCH_MAX_MOVES
) (
    input  logic                  clk_in,
    input  logic                  rst_in,
    input  logic                  ins_valid,
    input  payload_t              ins_payload,
    input  search_pkg::sort_key_t ins_key,
    input  logic                  deq,
    input  logic                  clear,
    output payload_t              top_payload,
    output search_pkg::sort_key_t top_key,
    output search_pkg::count_t    len,
    output logic                  full
);
    payload_t              payload_mem [DEPTH];
    search_pkg::sort_key_t key_mem     [DEPTH];

    // entries that keep their slot on insert (key >= new key, so ties stay ahead)
    logic [DEPTH-1:0] stays;
    logic [DEPTH-1:0] take_new;
    logic             do_ins;
    logic             do_deq;

    assign full        = (len == search_pkg::count_t'(DEPTH));
    assign top_payload = payload_mem[0];
    assign top_key     = key_mem[0];
    assign do_deq      = deq && (len != '0);
    assign do_ins      = ins_valid && !full && !deq;

    always_comb begin
        logic prev_stays;
        prev_stays = 1'b1;
        for (int i = 0; i < DEPTH; i++) begin
            stays[i]    = (i < int'(len)) && (key_mem[i] >= ins_key);
            take_new[i] = !stays[i] && prev_stays;
            prev_stays  = stays[i];
        end
    end

    always_ff @(posedge clk_in) begin
        if (do_deq) begin
            for (int i = 0; i < DEPTH - 1; i++) begin
                payload_mem[i] <= payload_mem[i + 1];
                key_mem[i]     <= key_mem[i + 1];
            end
        end else if (do_ins) begin
            // open a gap below the insertion point
            for (int i = DEPTH - 1; i > 0; i--) begin
                if (!stays[i] && !take_new[i]) begin
                    payload_mem[i] <= payload_mem[i - 1];
                    key_mem[i]     <= key_mem[i - 1];
                end
            end
            for (int i = 0; i < DEPTH; i++) begin
                if (take_new[i]) begin
                    payload_mem[i] <= ins_payload;
                    key_mem[i]     <= ins_key;
                end
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in || clear) begin
            len <= '0;
        end else if (do_deq) begin
            len <= len - 1'b1;
        end else if (do_ins) begin
            len <= len + 1'b1;
        end
    end

    // intake must hold off while full
    assert property (@(posedge clk_in) disable iff (rst_in) ins_valid |-> !full);
    // folder only pops while items remain
    assert property (@(posedge clk_in) disable iff (rst_in) deq |-> (len != '0));

endmodule

// ==== src/move_intake.sv ====
`timescale 1ns/1ps

module move_intake (
    input  logic                     clk_in,
    input  logic                     rst_in,
    input  search_pkg::scored_move_t item,
    input  logic                     item_req,
    output logic                     item_ack,
    input  logic                     full,
    input  logic                     folding,
    output logic                     ins_valid,
    output search_pkg::scored_move_t ins_payload,
    output search_pkg::sort_key_t    ins_key
);
    search_pkg::eval_t parent_score;

    // parent-side score with its sign bit flipped for unsigned ordering
    assign parent_score = -item.score;
    assign ins_key      = {~parent_score[$bits(parent_score)-1],
                           parent_score[$bits(parent_score)-2:0]};
    assign ins_payload  = item;

    // one insert per request, on the edge that raises ack
    assign ins_valid = item_req && !item_ack && !full && !folding;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            item_ack <= 1'b0;
        end else if (ins_valid) begin
            item_ack <= 1'b1;
        end else if (!item_req) begin
            item_ack <= 1'b0;
        end
    end

    // producer holds req until it sees ack
    assert property (@(posedge clk_in) disable iff (rst_in)
        $rose(item_ack) |-> item_req);

endmodule

// ==== src/window_regs.sv ====
`timescale 1ns/1ps
`include "search_settings.svh"

module window_regs (
    input  logic                clk_in,
    input  logic                rst_in,
    input  search_pkg::window_t cfg_window,
    input  logic                cfg_req,
    output logic                cfg_ack,
    output search_pkg::window_t window
);
    logic load;

    assign load = cfg_req && !cfg_ack;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            cfg_ack      <= 1'b0;
            // full window until software narrows it
            window.alpha <= -search_pkg::eval_t'(`SEARCH_SCORE_INF);
            window.beta  <= search_pkg::eval_t'(`SEARCH_SCORE_INF);
        end else if (load) begin
            cfg_ack <= 1'b1;
            window  <= cfg_window;
        end else if (!cfg_req) begin
            cfg_ack <= 1'b0;
        end
    end

    // writer holds req until it sees ack
    assert property (@(posedge clk_in) disable iff (rst_in)
        $rose(cfg_ack) |-> cfg_req);

endmodule

// ==== src/node_folder.sv ====
`timescale 1ns/1ps
`include "search_settings.svh"

module node_folder (
    input  logic                     clk_in,
    input  logic                     rst_in,
    input  logic                     fold_req,
    output logic                     fold_ack,
    input  search_pkg::window_t      window,
    input  search_pkg::scored_move_t top_payload,
    input  search_pkg::count_t       len,
    output logic                     deq,
    output logic                     clear,
    output logic                     folding,
    output search_pkg::fold_result_t result
);
    typedef enum logic [1:0] {
        fold_idle,
        fold_drain,
        fold_done,
        fold_release
    } fold_state_t;

    fold_state_t        state;
    search_pkg::move_t  best_move;
    search_pkg::eval_t  best_score;
    search_pkg::eval_t  alpha;
    logic               cutoff;
    search_pkg::count_t examined;
    search_pkg::eval_t  child_eval;
    logic               is_mate;
    logic               beta_cut;
    logic               last_item;

    // negamax flip with mates one ply further away counting one less
    assign is_mate    = top_payload.score <= -`SEARCH_MATE_BAND;
    assign child_eval = is_mate ? -top_payload.score - 16'sd1 : -top_payload.score;
    assign beta_cut   = child_eval > window.beta;
    assign last_item  = (len <= search_pkg::count_t'(1));

    assign deq     = (state == fold_drain) && (len != '0);
    assign clear   = (state == fold_done);
    // stall intake as soon as a request shows up
    assign folding = (state != fold_idle) || fold_req;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state    <= fold_idle;
            fold_ack <= 1'b0;
        end else begin
            case (state)
                fold_idle: begin
                    if (fold_req) begin
                        best_score <= search_pkg::eval_t'(`SEARCH_SCORE_NONE);
                        best_move  <= '0;
                        alpha      <= window.alpha;
                        cutoff     <= 1'b0;
                        examined   <= '0;
                        state      <= (len == '0) ? fold_done : fold_drain;
                    end
                end
                fold_drain: begin
                    if (len != '0) begin
                        examined <= examined + 1'b1;
                        if (child_eval > best_score) begin
                            best_score <= child_eval;
                            best_move  <= top_payload.move;
                        end
                        if (child_eval > alpha) begin
                            alpha <= child_eval;
                        end
                        cutoff <= beta_cut;
                    end
                    if (len == '0 || beta_cut || last_item) begin
                        state <= fold_done;
                    end
                end
                fold_done: begin
                    result   <= '{best_move, best_score, alpha, cutoff, examined};
                    fold_ack <= 1'b1;
                    state    <= fold_release;
                end
                default: begin
                    if (!fold_req) begin
                        fold_ack <= 1'b0;
                        state    <= fold_idle;
                    end
                end
            endcase
        end
    end

    // each drain cycle pops exactly one item while intake stays stalled
    assert property (@(posedge clk_in) disable iff (rst_in)
        (state == fold_drain) |=> (len == $past(len) - 1'b1));

endmodule

// ==== src/node_search_top.sv ====
`timescale 1ns/1ps
`include "search_settings.svh"

module node_search_top (
    input  logic                     clk_in,
    input  logic                     rst_in,
    input  search_pkg::scored_move_t item,
    input  logic                     item_req,
    output logic                     item_ack,
    input  search_pkg::window_t      cfg_window,
    input  logic                     cfg_req,
    output logic                     cfg_ack,
    input  logic                     fold_req,
    output logic                     fold_ack,
    output search_pkg::fold_result_t result
);
    logic                     ins_valid;
    search_pkg::scored_move_t ins_payload;
    search_pkg::sort_key_t    ins_key;
    logic                     deq;
    logic                     clear;
    logic                     folding;
    logic                     full;
    search_pkg::scored_move_t top_payload;
    search_pkg::count_t       len;
    search_pkg::window_t      window;

    stream_sorter #(
        .payload_t (search_pkg::scored_move_t),
        .DEPTH     (`SEARCH_MAX_MOVES)
    ) u_stream_sorter (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .ins_valid   (ins_valid),
        .ins_payload (ins_payload),
        .ins_key     (ins_key),
        .deq         (deq),
        .clear       (clear),
        .top_payload (top_payload),
        .top_key     (),
        .len         (len),
        .full        (full)
    );

    move_intake u_move_intake (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .item        (item),
        .item_req    (item_req),
        .item_ack    (item_ack),
        .full        (full),
        .folding     (folding),
        .ins_valid   (ins_valid),
        .ins_payload (ins_payload),
        .ins_key     (ins_key)
    );

    window_regs u_window_regs (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .cfg_window (cfg_window),
        .cfg_req    (cfg_req),
        .cfg_ack    (cfg_ack),
        .window     (window)
    );

    node_folder u_node_folder (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .fold_req    (fold_req),
        .fold_ack    (fold_ack),
        .window      (window),
        .top_payload (top_payload),
        .len         (len),
        .deq         (deq),
        .clear       (clear),
        .folding     (folding),
        .result      (result)
    );

endmodule

// ==== bench/tb_node_checks.svh ====
`ifndef TB_NODE_CHECKS_SVH
`define TB_NODE_CHECKS_SVH

// expected fold: stable sort by parent-side score, best first, then negamax with cutoff
function automatic search_pkg::fold_result_t fold_ref(input search_pkg::scored_move_t list[$],
                                                      input search_pkg::window_t win);
    search_pkg::scored_move_t order[$];
    search_pkg::fold_result_t res;
    int pos;
    int ce;
    int best;
    int alpha;
    order = {};
    foreach (list[i]) begin
        pos = order.size();
        // a later arrival goes behind equal scores
        while (pos > 0 && (-int'(order[pos-1].score)) < (-int'(list[i].score))) begin
            pos--;
        end
        order.insert(pos, list[i]);
    end
    res   = '0;
    best  = `SEARCH_SCORE_NONE;
    alpha = int'(win.alpha);
    for (int i = 0; i < order.size() && !res.cutoff; i++) begin
        ce = -int'(order[i].score);
        // mate found one ply deeper is worth one less
        if (int'(order[i].score) <= -`SEARCH_MATE_BAND) begin
            ce = ce - 1;
        end
        res.examined = res.examined + 1'b1;
        if (ce > best) begin
            best          = ce;
            res.best_move = order[i].move;
        end
        if (ce > alpha) begin
            alpha = ce;
        end
        if (ce > int'(win.beta)) begin
            res.cutoff = 1'b1;
        end
    end
    res.best_score = search_pkg::eval_t'(best);
    res.new_alpha  = search_pkg::eval_t'(alpha);
    return res;
endfunction

task automatic note_fail(input string msg);
    $display("FAIL @%0t ns: %s", $time, msg);
    errors++;
endtask

task automatic check_result(input search_pkg::fold_result_t got,
                            input search_pkg::fold_result_t exp, input string what);
    if (got !== exp) begin
        note_fail($sformatf("%s: got move %h score %0d alpha %0d cut %0b n %0d, %s",
            what, got.best_move, got.best_score, got.new_alpha, got.cutoff, got.examined,
            $sformatf("expected move %h score %0d alpha %0d cut %0b n %0d",
                exp.best_move, exp.best_score, exp.new_alpha, exp.cutoff, exp.examined)));
    end
endtask

task automatic check_window(input search_pkg::window_t got, input search_pkg::window_t exp,
                            input string what);
    if (got !== exp) begin
        note_fail($sformatf("%s: window got %0d..%0d, expected %0d..%0d",
                            what, got.alpha, got.beta, exp.alpha, exp.beta));
    end
endtask

task automatic wait_item_ack(output bit seen);
    int n;
    n = 0;
    do begin
        @(negedge clk_in);
        n++;
    end while (!item_ack && n < HS_TIMEOUT);
    seen = item_ack;
endtask

// req stays high when no ack arrives
task automatic offer_item(input search_pkg::scored_move_t it, output bit seen);
    @(posedge clk_in);
    item     <= it;
    item_req <= 1'b1;
    wait_item_ack(seen);
endtask

task automatic release_item();
    int n;
    n = 0;
    @(posedge clk_in);
    item_req <= 1'b0;
    do begin
        @(negedge clk_in);
        n++;
    end while (item_ack && n < HS_TIMEOUT);
    if (item_ack) begin
        $display("item_ack stayed high after item_req dropped, at %0t ns", $time);
        errors++;
    end
endtask

task automatic send_items(input search_pkg::scored_move_t list[$]);
    bit seen;
    foreach (list[i]) begin
        offer_item(list[i], seen);
        if (!seen) begin
            $display("item_ack never rose for item %0d, at %0t ns", i, $time);
            errors++;
        end
        release_item();
    end
endtask

task automatic write_window(input search_pkg::window_t w);
    int n;
    n = 0;
    @(posedge clk_in);
    cfg_window <= w;
    cfg_req    <= 1'b1;
    do begin
        @(negedge clk_in);
        n++;
    end while (!cfg_ack && n < HS_TIMEOUT);
    if (!cfg_ack) begin
        $display("cfg_ack never rose for a window write, at %0t ns", $time);
        errors++;
    end
    n = 0;
    @(posedge clk_in);
    cfg_req <= 1'b0;
    do begin
        @(negedge clk_in);
        n++;
    end while (cfg_ack && n < HS_TIMEOUT);
    if (cfg_ack) begin
        $display("cfg_ack stayed high after cfg_req dropped, at %0t ns", $time);
        errors++;
    end
endtask

task automatic run_fold(output search_pkg::fold_result_t res);
    int n;
    n = 0;
    @(posedge clk_in);
    fold_req <= 1'b1;
    do begin
        @(negedge clk_in);
        n++;
    end while (!fold_ack && n < HS_TIMEOUT);
    if (!fold_ack) begin
        $display("fold_ack never rose after a fold request, at %0t ns", $time);
        errors++;
    end
    res = result;
    n   = 0;
    @(posedge clk_in);
    fold_req <= 1'b0;
    do begin
        @(negedge clk_in);
        n++;
    end while (fold_ack && n < HS_TIMEOUT);
    if (fold_ack) begin
        $display("fold_ack stayed high after fold_req dropped, at %0t ns", $time);
        errors++;
    end
endtask

`endif

// ==== bench/tb_node_search.sv ====
`timescale 1ns/1ps
`include "search_settings.svh"

module tb_node_search;

    // longest fold is 16 items plus overhead
    localparam int HS_TIMEOUT = 64;

    logic                     clk_in;
    logic                     rst_in;
    search_pkg::scored_move_t item;
    logic                     item_req;
    logic                     item_ack;
    search_pkg::window_t      cfg_window;
    logic                     cfg_req;
    logic                     cfg_ack;
    logic                     fold_req;
    logic                     fold_ack;
    search_pkg::fold_result_t result;

    int                       errors;
    int                       tests_run;
    int                       tests_failed;
    int                       mark;
    int                       best_ce;
    bit                       seen;
    search_pkg::scored_move_t items[$];
    search_pkg::scored_move_t single[$];
    search_pkg::scored_move_t extra;
    search_pkg::fold_result_t got;
    search_pkg::fold_result_t exp_res;
    search_pkg::window_t      full_win;
    search_pkg::window_t      narrow_win;

    node_search_top u_node_search_top (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .item       (item),
        .item_req   (item_req),
        .item_ack   (item_ack),
        .cfg_window (cfg_window),
        .cfg_req    (cfg_req),
        .cfg_ack    (cfg_ack),
        .fold_req   (fold_req),
        .fold_ack   (fold_ack),
        .result     (result)
    );

    `include "tb_node_checks.svh"

    function automatic search_pkg::scored_move_t make_item(input logic [15:0] mv, input int sc);
        search_pkg::scored_move_t it;
        it.move  = search_pkg::move_t'(mv);
        it.score = search_pkg::eval_t'(sc);
        return it;
    endfunction

    // scores stay well inside the window and away from the mate band
    task automatic fill_random(input int n);
        items = {};
        for (int i = 0; i < n; i++) begin
            items.push_back(make_item(16'($urandom), int'($urandom % 4001) - 2000));
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %s: passed", name);
        end else begin
            $display("test %s: failed", name);
            tests_failed++;
        end
    endtask

    initial begin
        clk_in = 1'b0;
        forever #10 clk_in = ~clk_in;
    end

    initial begin
        rst_in       = 1'b1;
        item         = '0;
        item_req     = 1'b0;
        cfg_window   = '0;
        cfg_req      = 1'b0;
        fold_req     = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        void'($urandom(32'hdb26b314));
        full_win.alpha = search_pkg::eval_t'(-`SEARCH_SCORE_INF);
        full_win.beta  = search_pkg::eval_t'(`SEARCH_SCORE_INF);
        repeat (4) @(posedge clk_in);
        rst_in <= 1'b0;

        mark = errors;
        check_window(u_node_search_top.window, full_win, "window after reset");
        exp_res            = '0;
        exp_res.best_score = search_pkg::eval_t'(`SEARCH_SCORE_NONE);
        exp_res.new_alpha  = search_pkg::eval_t'(-`SEARCH_SCORE_INF);
        run_fold(got);
        check_result(got, exp_res, "empty node");
        report_test("empty node", mark);

        mark = errors;
        fill_random(1 + int'($urandom % 16));
        send_items(items);
        run_fold(got);
        check_result(got, fold_ref(items, full_win), "random items");
        if (got.cutoff || int'(got.examined) != items.size()) begin
            note_fail("full window cut off or skipped items");
        end
        report_test("random items, full window", mark);

        mark    = errors;
        best_ce = -32768;
        foreach (items[i]) begin
            if (-int'(items[i].score) > best_ce) begin
                best_ce = -int'(items[i].score);
            end
        end
        narrow_win.alpha = search_pkg::eval_t'(best_ce - 10);
        narrow_win.beta  = search_pkg::eval_t'(best_ce - 1);
        write_window(narrow_win);
        check_window(u_node_search_top.window, narrow_win, "narrow window write");
        send_items(items);
        run_fold(got);
        check_result(got, fold_ref(items, narrow_win), "narrow window");
        if (!got.cutoff || got.examined != 1) begin
            note_fail("narrow window did not cut off at the first item");
        end
        write_window(full_win);
        check_window(u_node_search_top.window, full_win, "full window write");
        send_items(items);
        run_fold(got);
        check_result(got, fold_ref(items, full_win), "window restored");
        if (got.cutoff) begin
            note_fail("cutoff after the full window was restored");
        end
        report_test("beta cutoff", mark);

        mark  = errors;
        items = {make_item(16'h1111, 100), make_item(16'h2222, -32750), make_item(16'h3333, -5)};
        send_items(items);
        run_fold(got);
        check_result(got, fold_ref(items, full_win), "mate score");
        if (got.best_score != 16'sd32749) begin
            note_fail("mate score was not pulled one ply closer");
        end
        items = {make_item(16'h0a0a, -500), make_item(16'h0b0b, -500),
                 make_item(16'h0c0c, -500), make_item(16'h0d0d, 300)};
        send_items(items);
        run_fold(got);
        check_result(got, fold_ref(items, full_win), "equal scores");
        if (got.best_move != search_pkg::move_t'(16'h0a0a)) begin
            note_fail("equal scores did not keep the first arrival as best");
        end
        report_test("mate and ties", mark);

        mark = errors;
        fill_random(`SEARCH_MAX_MOVES);
        send_items(items);
        extra = make_item(16'h7e57, -1234);
        offer_item(extra, seen);
        if (seen) begin
            note_fail("seventeenth item was accepted while the sorter was full");
        end
        run_fold(got);
        check_result(got, fold_ref(items, full_win), "full sorter");
        wait_item_ack(seen);
        if (!seen) begin
            $display("held item was never accepted after the fold, at %0t ns", $time);
            errors++;
        end
        release_item();
        single = {extra};
        run_fold(got);
        check_result(got, fold_ref(single, full_win), "held item alone");
        report_test("back-pressure", mark);

        $display("tests run %0d, tests failed %0d, check errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+src
+incdir+bench
src/search_pkg.sv
src/stream_sorter.sv
src/move_intake.sv
src/window_regs.sv
src/node_folder.sv
src/node_search_top.sv
bench/tb_node_search.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the node search testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_node_search -f all.f --Mdir obj_dir -o tb_node_search \
    && ./obj_dir/tb_node_search > sim.log 2>&1
cat sim.log 2>/dev/null

grep -q "^Everything OK$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
